/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_bcd_store_unit
FILELIST = bcd_store_unit.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with $(SIM), run it into $(LOG), check the result"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bcd_store_unit.f */
+incdir+test
source/bcd_pkg.sv
source/axil_pkg.sv
source/bcd_conv_if.sv
source/axil_bcd_regs.sv
source/bcd_seq_fsm.sv
source/bit_counter.sv
source/dabble_datapath.sv
source/bcd_store_unit.sv
test/tb_bcd_store_unit.sv

/* source/axil_bcd_regs.sv */
module axil_bcd_regs
    import axil_pkg::*, bcd_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [DATA_W-1:0] wdata,
    input  logic              wvalid,
    output logic              wready,
    output logic [RESP_W-1:0] bresp,
    output logic              bvalid,
    input  logic              bready,

    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [DATA_W-1:0] rdata,
    output logic [RESP_W-1:0] rresp,
    output logic              rvalid,
    input  logic              rready,

    bcd_conv_if.regs          conv
);

    logic              wr_fire;
    logic              rd_fire;
    logic [DATA_W-1:0] bin_lo_q;
    logic [DATA_W-1:0] bin_hi_q;
    logic              sign_q;
    logic              start_q;
    logic              done_q;
    logic              error_q;
    logic [DATA_W-1:0] rd_mux;

    // ==================================================
    // Write channel
    // ==================================================

    // Address and data are taken together in one beat
    assign wr_fire = awready && awvalid && wvalid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            // One-cycle ready pulse, held off while a response is pending
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    assign bresp = RESP_OKAY;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bin_lo_q <= '0;
            bin_hi_q <= '0;
            sign_q   <= 1'b0;
            start_q  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (wr_fire) begin
                case (awaddr)
                    REG_BIN_LO: bin_lo_q <= wdata;
                    REG_BIN_HI: bin_hi_q <= wdata;
                    REG_CTRL: begin
                        // Sign is kept even when the start is dropped
                        sign_q <= wdata[1];
                        if (wdata[0] && !conv.busy && !start_q) begin
                            start_q <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    assign conv.start   = start_q;
    assign conv.operand = {bin_hi_q, bin_lo_q};
    assign conv.sign    = sign_q;

    // ==================================================
    // Sticky status
    // ==================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_q  <= 1'b0;
            error_q <= 1'b0;
        end else if (start_q) begin
            // Accepted start clears the previous outcome
            done_q  <= 1'b0;
            error_q <= 1'b0;
        end else if (conv.done) begin
            done_q  <= 1'b1;
            error_q <= conv.error;
        end
    end

    // ==================================================
    // Read channel
    // ==================================================

    assign rd_fire = arready && arvalid;

    always_comb begin
        case (araddr)
            REG_CTRL:   rd_mux = {{(DATA_W-2){1'b0}}, sign_q, 1'b0};
            REG_STATUS: rd_mux = {{(DATA_W-3){1'b0}}, error_q, done_q, conv.busy};
            REG_BIN_LO: rd_mux = bin_lo_q;
            REG_BIN_HI: rd_mux = bin_hi_q;
            REG_BCD0:   rd_mux = conv.result[31:0];
            REG_BCD1:   rd_mux = conv.result[63:32];
            // Digits 17 and 16 low, sign on top
            REG_BCD2:   rd_mux = {conv.result[PACKED_W-1], 23'd0, conv.result[71:64]};
            // Unmapped offsets read as zero
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rdata  <= rd_mux;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    assign rresp = RESP_OKAY;

    // Responses stay up until the master takes them
    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid);
    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* source/axil_pkg.sv */
package axil_pkg;

    // ==================================================
    // AXI4-Lite bus widths
    // ==================================================

    localparam int ADDR_W = 5;
    localparam int DATA_W = 32;
    localparam int RESP_W = 2;

    // ==================================================
    // Register map
    // ==================================================

    // Bit 0 start, bit 1 sign
    localparam logic [ADDR_W-1:0] REG_CTRL = 5'h00;

    // Bit 0 busy, bit 1 done, bit 2 error
    localparam logic [ADDR_W-1:0] REG_STATUS = 5'h04;

    // Operand halves
    localparam logic [ADDR_W-1:0] REG_BIN_LO = 5'h08;
    localparam logic [ADDR_W-1:0] REG_BIN_HI = 5'h0C;

    // Digits 7..0, digits 15..8, then digits 17..16 plus sign in bit 31
    localparam logic [ADDR_W-1:0] REG_BCD0 = 5'h10;
    localparam logic [ADDR_W-1:0] REG_BCD1 = 5'h14;
    localparam logic [ADDR_W-1:0] REG_BCD2 = 5'h18;

    // Only response the slave ever returns
    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

endpackage

/* source/bcd_conv_if.sv */
interface bcd_conv_if
    import bcd_pkg::*;
();

    // Request side, owned by the register block
    logic                start;
    logic [BIN_W-1:0]    operand;
    logic                sign;

    // Response side, owned by the conversion core
    logic                busy;
    logic                done;
    logic                error;
    logic [PACKED_W-1:0] result;

    modport regs (
        output start,
        output operand,
        output sign,
        input  busy,
        input  done,
        input  error,
        input  result
    );

    modport core (
        input  start,
        input  operand,
        input  sign,
        output busy,
        output done,
        output error,
        output result
    );

endinterface

/* source/bcd_pkg.sv */
package bcd_pkg;

    // ==================================================
    // Operand and result formats
    // ==================================================

    // Unsigned integer magnitude width
    localparam int BIN_W = 64;

    // Bits per packed BCD digit
    localparam int DIGIT_W = 4;

    // Digits stored in the 8087 word
    localparam int OUT_DIGITS = 18;

    // 2^64 needs 20 decimal digits, so the shifter keeps all of them
    localparam int INT_DIGITS = 20;

    // Packed word, sign in the top bit
    localparam int PACKED_W = 80;

    // Zero gap between the sign and digit 17
    localparam int PAD_W = PACKED_W - 1 - OUT_DIGITS * DIGIT_W;

    // Remaining bit counter must hold BIN_W itself
    localparam int CNT_W = $clog2(BIN_W + 1);

    // ==================================================
    // Sequencer states and datapath opcodes
    // ==================================================

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        PACK
    } conv_state_t;

    typedef enum logic [1:0] {
        DP_HOLD,
        DP_LOAD,
        DP_SHIFT,
        DP_PACK
    } dp_op_t;

endpackage

/* source/bcd_seq_fsm.sv */
module bcd_seq_fsm
    import bcd_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  logic   cnt_zero,
    output logic   cnt_load,
    output logic   cnt_dec,
    output dp_op_t dp_op,
    output logic   busy,
    output logic   done_pulse
);

    conv_state_t state;
    conv_state_t state_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ==================================================
    // Next state and datapath control
    // ==================================================

    always_comb begin
        state_next = state;
        cnt_load   = 1'b0;
        cnt_dec    = 1'b0;
        dp_op      = DP_HOLD;
        case (state)
            IDLE: begin
                // Operand capture and counter load happen with start
                if (start) begin
                    cnt_load   = 1'b1;
                    dp_op      = DP_LOAD;
                    state_next = SHIFT;
                end
            end
            SHIFT: begin
                // One operand bit per cycle until none remain
                if (cnt_zero) begin
                    state_next = PACK;
                end else begin
                    cnt_dec = 1'b1;
                    dp_op   = DP_SHIFT;
                end
            end
            PACK: begin
                dp_op      = DP_PACK;
                state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    assign busy       = (state != IDLE);
    // Status done is set on the edge that ends PACK
    assign done_pulse = (state == PACK);

    // A start in IDLE always leaves a full operand to shift
    a_start_loads: assert property (@(posedge clk) disable iff (reset)
        state == IDLE && start |=> state == SHIFT && !cnt_zero);

endmodule

/* source/bcd_store_unit.sv */
module bcd_store_unit
    import axil_pkg::*, bcd_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [DATA_W-1:0] wdata,
    input  logic              wvalid,
    output logic              wready,
    output logic [RESP_W-1:0] bresp,
    output logic              bvalid,
    input  logic              bready,

    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [DATA_W-1:0] rdata,
    output logic [RESP_W-1:0] rresp,
    output logic              rvalid,
    input  logic              rready
);

    // Core control wires
    logic   cnt_load;
    logic   cnt_dec;
    logic   cnt_zero;
    dp_op_t dp_op;

    bcd_conv_if conv ();

    // ==================================================
    // Host side
    // ==================================================

    axil_bcd_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .conv    (conv.regs)
    );

    // ==================================================
    // Conversion core
    // ==================================================

    bcd_seq_fsm u_fsm (
        .clk        (clk),
        .reset      (reset),
        .start      (conv.start),
        .cnt_zero   (cnt_zero),
        .cnt_load   (cnt_load),
        .cnt_dec    (cnt_dec),
        .dp_op      (dp_op),
        .busy       (conv.busy),
        .done_pulse (conv.done)
    );

    bit_counter u_cnt (
        .clk   (clk),
        .reset (reset),
        .load  (cnt_load),
        .dec   (cnt_dec),
        .zero  (cnt_zero)
    );

    dabble_datapath u_dp (
        .clk      (clk),
        .reset    (reset),
        .op       (dp_op),
        .operand  (conv.operand),
        .sign     (conv.sign),
        .result   (conv.result),
        .overflow (conv.error)
    );

endmodule

/* source/bit_counter.sv */
module bit_counter
    import bcd_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  logic dec,
    output logic zero
);

    // Operand bits still to be shifted
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= CNT_W'(BIN_W);
        end else if (dec) begin
            count <= count - 1'b1;
        end
    end

    assign zero = (count == '0);

    // Sequencer never underflows the counter
    a_no_dec_at_zero: assert property (@(posedge clk) disable iff (reset)
        dec |-> !zero);

endmodule

/* source/dabble_datapath.sv */
module dabble_datapath
    import bcd_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  dp_op_t              op,
    input  logic [BIN_W-1:0]    operand,
    input  logic                sign,
    output logic [PACKED_W-1:0] result,
    output logic                overflow
);

    localparam int BCD_W = INT_DIGITS * DIGIT_W;
    localparam int OUT_W = OUT_DIGITS * DIGIT_W;

    logic [BIN_W-1:0] bin_q;
    logic             sign_q;
    logic [BCD_W-1:0] digits_q;
    logic [BCD_W-1:0] adjusted;

    // ==================================================
    // Add-3 correction
    // ==================================================

    // Digits of five or more would pass nine once doubled
    always_comb begin
        adjusted = digits_q;
        for (int i = 0; i < INT_DIGITS; i++) begin
            if (digits_q[i*DIGIT_W +: DIGIT_W] >= 4'd5) begin
                adjusted[i*DIGIT_W +: DIGIT_W] = digits_q[i*DIGIT_W +: DIGIT_W] + 4'd3;
            end
        end
    end

    // Operand shifter and digit array
    always_ff @(posedge clk) begin
        case (op)
            DP_LOAD: begin
                bin_q    <= operand;
                sign_q   <= sign;
                digits_q <= '0;
            end
            DP_SHIFT: begin
                // Adjust and shift in one step, operand MSB enters digit 0
                digits_q <= {adjusted[BCD_W-2:0], bin_q[BIN_W-1]};
                bin_q    <= {bin_q[BIN_W-2:0], 1'b0};
            end
            default: ;
        endcase
    end

    // ==================================================
    // 8087 packing
    // ==================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else if (op == DP_PACK) begin
            result <= {sign_q, {PAD_W{1'b0}}, digits_q[OUT_W-1:0]};
        end
    end

    // Digits 18 and 19 do not fit the 8087 word
    // valid from PACK on, sampled by the status logic with done
    assign overflow = |digits_q[BCD_W-1:OUT_W];

    function automatic logic digits_ok(input logic [BCD_W-1:0] d);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < INT_DIGITS; i++) begin
            if (d[i*DIGIT_W +: DIGIT_W] > 4'd9) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // All 64 adjust steps together must leave only decimal digits
    a_digits_decimal: assert property (@(posedge clk) disable iff (reset)
        op == DP_PACK |-> digits_ok(digits_q));

endmodule

/* test/bcd_ref_model.svh */
`ifndef BCD_REF_MODEL_SVH
`define BCD_REF_MODEL_SVH

// ==================================================
// AXI4-Lite master tasks
// ==================================================

// Address and data go out together, response taken with bready held high
task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    int waited;
    waited = 0;
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    // Beat is accepted on the edge that sees the ready pulse
    do begin
        @(posedge clk);
        waited++;
    end while (!awready && !wready && waited < HANDSHAKE_LIMIT);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (!awready && !wready) begin
        $display("At %0t the write to 0x%02h was never accepted", $time, addr);
        err_count++;
    end else if (!awready || !wready) begin
        // Address and data ready rise together
        $display("** Error at %0t: awready and wready expected 1 and 1, got %0b and %0b",
                 $time, awready, wready);
        err_count++;
    end
    waited = 0;
    do begin
        @(posedge clk);
        waited++;
    end while (!bvalid && waited < HANDSHAKE_LIMIT);
    bready <= 1'b0;
    if (!bvalid) begin
        $display("At %0t the write to 0x%02h got no response", $time, addr);
        err_count++;
    end else if (bresp !== RESP_OKAY) begin
        $display("** Error at %0t: bresp expected %0h, got %0h", $time, RESP_OKAY, bresp);
        err_count++;
    end
endtask

task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                        output logic [RESP_W-1:0] resp);
    int waited;
    waited = 0;
    data   = '0;
    resp   = RESP_OKAY;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    do begin
        @(posedge clk);
        waited++;
    end while (!arready && waited < HANDSHAKE_LIMIT);
    arvalid <= 1'b0;
    waited = 0;
    // Data is stable while rvalid waits for this edge
    do begin
        @(posedge clk);
        waited++;
    end while (!rvalid && waited < HANDSHAKE_LIMIT);
    rready <= 1'b0;
    if (!rvalid) begin
        $display("At %0t the read of 0x%02h got no data", $time, addr);
        err_count++;
    end else begin
        data = rdata;
        resp = rresp;
    end
endtask

// ==================================================
// Reference conversion
// ==================================================

// Repeated division by ten, digit 0 first
function automatic void ref_bcd(input logic [BIN_W-1:0] value, input logic sign,
                                output logic [PACKED_W-1:0] word, output logic overflow);
    logic [BIN_W-1:0] rest;
    rest = value;
    word = '0;
    word[PACKED_W-1] = sign;
    for (int i = 0; i < OUT_DIGITS; i++) begin
        word[i*4 +: 4] = 4'(rest % 64'd10);
        rest = rest / 64'd10;
    end
    // Anything left over lands in digit 18 or higher
    overflow = (rest != '0);
endfunction

`endif

/* test/tb_bcd_store_unit.sv */
module tb_bcd_store_unit
    import axil_pkg::*, bcd_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD      = 100;
    localparam int    HANDSHAKE_LIMIT = 20;
    localparam int    POLL_LIMIT      = 100;
    localparam int    RANDOM_RUNS     = 200;
    // 230 conversions at 150 cycles each
    localparam longint WATCHDOG_NS    = 64'd230 * 150 * CLK_PERIOD;

    logic              clk;
    logic              reset;
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic              wvalid;
    logic              wready;
    logic [RESP_W-1:0] bresp;
    logic              bvalid;
    logic              bready;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    logic [RESP_W-1:0] rresp;
    logic              rvalid;
    logic              rready;

    integer seed = 32'h3ea4;
    int     err_count    = 0;
    int     check_count  = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     errors_before;

    bcd_store_unit UUT (.*);

    `include "bcd_ref_model.svh"

    // ==================================================
    // Check helpers
    // ==================================================

    function automatic string reg_name(input logic [ADDR_W-1:0] addr);
        case (addr)
            REG_CTRL:   return "REG_CTRL";
            REG_STATUS: return "REG_STATUS";
            REG_BIN_LO: return "REG_BIN_LO";
            REG_BIN_HI: return "REG_BIN_HI";
            REG_BCD0:   return "REG_BCD0";
            REG_BCD1:   return "REG_BCD1";
            REG_BCD2:   return "REG_BCD2";
            default:    return $sformatf("offset 0x%02h", addr);
        endcase
    endfunction

    task automatic read_and_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expected);
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
        axi_read(addr, data, resp);
        check_count++;
        if (data !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h",
                     $time, reg_name(addr), expected, data);
            err_count++;
        end
        if (resp !== RESP_OKAY) begin
            $display("** Error at %0t: rresp of %s expected %0h, got %0h",
                     $time, reg_name(addr), RESP_OKAY, resp);
            err_count++;
        end
    endtask

    // Poll status, then compare status and the three result words with the model
    task automatic check_result(input logic [BIN_W-1:0] value, input logic sign);
        logic [PACKED_W-1:0] exp_word;
        logic                exp_ovf;
        logic [DATA_W-1:0]   status;
        logic [RESP_W-1:0]   resp;
        int                  polls;
        ref_bcd(value, sign, exp_word, exp_ovf);
        polls = 0;
        do begin
            axi_read(REG_STATUS, status, resp);
            polls++;
        end while (!status[1] && polls < POLL_LIMIT);
        if (!status[1]) begin
            $display("At %0t the conversion of %h never reported done", $time, value);
            err_count++;
        end
        read_and_check(REG_STATUS, {29'd0, exp_ovf, 2'b10});
        read_and_check(REG_BCD0, exp_word[31:0]);
        read_and_check(REG_BCD1, exp_word[63:32]);
        read_and_check(REG_BCD2, {exp_word[PACKED_W-1], 23'd0, exp_word[71:64]});
    endtask

    task automatic convert_and_check(input logic [BIN_W-1:0] value, input logic sign);
        axi_write(REG_BIN_LO, value[31:0]);
        axi_write(REG_BIN_HI, value[63:32]);
        axi_write(REG_CTRL, {30'd0, sign, 1'b1});
        check_result(value, sign);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count != errors_before) begin
            tests_failed++;
            $display("test %-18s FAIL, %0d errors", name, err_count - errors_before);
        end else begin
            $display("test %-18s ok", name);
        end
        errors_before = err_count;
    endtask

    // ==================================================
    // Clock and watchdog
    // ==================================================

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation timed out after %0t", $time);
        $display("sim failed");
        $finish;
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        logic [BIN_W-1:0] values [5];
        logic [BIN_W-1:0] first_op;
        logic [BIN_W-1:0] second_op;
        logic             first_sign;
        logic             second_sign;
        logic [5:0]       shift;
        logic [DATA_W-1:0] status;
        logic [RESP_W-1:0] resp;

        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        errors_before = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Everything mapped comes up zero
        read_and_check(REG_CTRL, '0);
        read_and_check(REG_STATUS, '0);
        read_and_check(REG_BIN_LO, '0);
        read_and_check(REG_BIN_HI, '0);
        read_and_check(REG_BCD0, '0);
        read_and_check(REG_BCD1, '0);
        read_and_check(REG_BCD2, '0);
        end_test("reset_state");

        // Edges of the 18 digit range, both signs
        values = '{64'd0, 64'd9, 64'd999999999999999999, 64'd1000000000000000000,
                   {BIN_W{1'b1}}};
        for (int v = 0; v < 5; v++) begin
            convert_and_check(values[v], 1'b0);
            convert_and_check(values[v], 1'b1);
        end
        end_test("directed_values");

        // Random shift spreads the magnitudes over all widths
        for (int n = 0; n < RANDOM_RUNS; n++) begin
            first_op   = {$random(seed), $random(seed)};
            shift      = 6'($random(seed));
            first_sign = 1'($random(seed));
            convert_and_check(first_op >> shift, first_sign);
        end
        end_test("random_conversions");

        // Second start lands while the first conversion is running
        first_op    = {$random(seed), $random(seed)};
        second_op   = {$random(seed), $random(seed)};
        first_sign  = 1'($random(seed));
        second_sign = ~first_sign;
        axi_write(REG_BIN_LO, first_op[31:0]);
        axi_write(REG_BIN_HI, first_op[63:32]);
        axi_write(REG_CTRL, {30'd0, first_sign, 1'b1});
        axi_write(REG_BIN_LO, second_op[31:0]);
        axi_write(REG_BIN_HI, second_op[63:32]);
        axi_read(REG_STATUS, status, resp);
        if (!status[0]) begin
            $display("At %0t the core was not busy when the second start was sent", $time);
            err_count++;
        end
        axi_write(REG_CTRL, {30'd0, second_sign, 1'b1});
        check_result(first_op, first_sign);
        read_and_check(REG_BIN_LO, second_op[31:0]);
        read_and_check(REG_BIN_HI, second_op[63:32]);
        read_and_check(REG_CTRL, {30'd0, second_sign, 1'b0});
        end_test("start_while_busy");

        // Operand readback, unmapped offset, sticky done
        first_op = {$random(seed), $random(seed)};
        axi_write(REG_BIN_LO, first_op[31:0]);
        axi_write(REG_BIN_HI, first_op[63:32]);
        read_and_check(REG_BIN_LO, first_op[31:0]);
        read_and_check(REG_BIN_HI, first_op[63:32]);
        axi_write(5'h1C, 32'hdead_beef);
        read_and_check(5'h1C, '0);
        read_and_check(REG_BIN_LO, first_op[31:0]);
        for (int r = 0; r < 3; r++) begin
            axi_read(REG_STATUS, status, resp);
            check_count++;
            if (!status[1]) begin
                $display("** Error at %0t: REG_STATUS done expected 1, got 0", $time);
                err_count++;
            end
        end
        axi_write(REG_CTRL, {30'd0, 1'b1, 1'b1});
        // Only busy is left right after an accepted start
        read_and_check(REG_STATUS, 32'h1);
        check_result(first_op, 1'b1);
        end_test("register_access");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
